//--- Makefile
TOP := peak_sim_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build peak_sim with verilator and run $(TOP)"
	@echo "  clean  remove the verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f peak_sim.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- dv/peak_sim_assertions.sv
`timescale 1ns/1ns

module peak_sim_assertions #(
    parameter int N_OUT = 2
) (
    input logic                                clk,
    input logic                                rst,
    input peak_sim_pkg::bus_req_t              i_bus_req,
    input peak_sim_pkg::bus_rsp_t              i_bus_rsp,
    input peak_sim_pkg::sample_t [N_OUT-1:0]   i_out
);

    int unsigned fail_cnt = 0;   // read by the testbench at the end

    // ----------------------------------------
    // bus handshake
    // ----------------------------------------
    ack_after_strobe: assert property (@(posedge clk) disable iff (rst)
        (i_bus_req.wen || i_bus_req.ren) |=> i_bus_rsp.ack)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("ack missing one cycle after a strobe");
    end

    ack_needs_strobe: assert property (@(posedge clk) disable iff (rst)
        i_bus_rsp.ack |-> $past(i_bus_req.wen || i_bus_req.ren))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("ack without a strobe the cycle before");
    end

    // dacs held at zero through reset
    out_zero_in_reset: assert property (@(posedge clk) rst |-> (i_out == '0))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("fast outputs not zero during reset");
    end

endmodule

bind peak_sim_top peak_sim_assertions #(.N_OUT(N_OUT)) u_assertions (
    .clk       (clk),
    .rst       (rst),
    .i_bus_req (i_bus),
    .i_bus_rsp (o_bus),
    .i_out     (o_out)
);

//--- dv/peak_sim_tb.sv
`timescale 1ns/1ns

module peak_sim_tb;

    localparam int N_OUT      = 2;
    localparam int MAX_CYCLES = 4000;   // all tests fit in well under 1000

    logic                              clk;
    logic                              rst;
    peak_sim_pkg::sample_t             in1;
    peak_sim_pkg::sample_t             in2;
    peak_sim_pkg::bus_req_t            bus_req;
    peak_sim_pkg::bus_rsp_t            bus_rsp;
    peak_sim_pkg::sample_t [N_OUT-1:0] dut_out;
    int                                seed;
    int                                cycles = 0;

    peak_sim_top #(.N_OUT(N_OUT)) uut (
        .clk   (clk),
        .rst   (rst),
        .i_in1 (in1),
        .i_in2 (in2),
        .i_bus (bus_req),
        .o_out (dut_out),
        .o_bus (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 100 MHz
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            stop_on_error();
        end
    end

    // ----------------------------------------
    // reference arithmetic
    // ----------------------------------------
    function automatic peak_sim_pkg::sample_t clip(input int v);
        if (v > 8191) return 14'sd8191;
        if (v < -8192) return peak_sim_pkg::sample_t'(-8192);
        return peak_sim_pkg::sample_t'(v);
    endfunction

    function automatic logic [31:0] sext_word(input peak_sim_pkg::sample_t v);
        return {{18{v[13]}}, v};
    endfunction

    function automatic peak_sim_pkg::sample_t route_expect(input int sel, input int a,
                                                           input int b);
        case (sel)
            peak_sim_pkg::SRC_IN1:  return peak_sim_pkg::sample_t'(a);
            peak_sim_pkg::SRC_IN2:  return peak_sim_pkg::sample_t'(b);
            peak_sim_pkg::SRC_SUM:  return clip(a + b);
            default:                return clip(a - b);   // difference
        endcase
    endfunction

    // ----------------------------------------
    // bus and compare tasks
    // ----------------------------------------
    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic bus_write(input logic [19:0] addr, input logic [31:0] data);
        @(negedge clk);
        bus_req.addr  = {12'd0, addr};
        bus_req.wdata = data;
        bus_req.wen   = 1'b1;
        @(negedge clk);
        bus_req.wen = 1'b0;   // one-cycle strobe
        if (!bus_rsp.ack) begin
            $display("write to 0x%05h got no ack one cycle after the strobe", addr);
            stop_on_error();
        end
        if (bus_rsp.err !== 1'b0) begin
            $display("write to 0x%05h returned a bus error", addr);
            stop_on_error();
        end
    endtask

    task automatic bus_read(input logic [19:0] addr, output logic [31:0] data);
        @(negedge clk);
        bus_req.addr = {12'd0, addr};
        bus_req.ren  = 1'b1;
        @(negedge clk);
        bus_req.ren = 1'b0;
        data        = bus_rsp.rdata;   // valid with ack
        if (!bus_rsp.ack) begin
            $display("read of 0x%05h got no ack one cycle after the strobe", addr);
            stop_on_error();
        end
        if (bus_rsp.err !== 1'b0) begin
            $display("read of 0x%05h returned a bus error", addr);
            stop_on_error();
        end
    endtask

    task automatic compare_sample(input string test, input peak_sim_pkg::sample_t exp,
                                  input peak_sim_pkg::sample_t act);
        if (act !== exp) begin
            $display("error %s: expected %0d, actual %0d", test, exp, act);
            stop_on_error();
        end
    endtask

    task automatic compare_word(input string test, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s: expected 0x%08h, actual 0x%08h", test, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_reg(input string test, input logic [19:0] addr,
                             input logic [31:0] exp);
        logic [31:0] rd;
        bus_read(addr, rd);
        compare_word(test, exp, rd);
    endtask

    task automatic write_check(input string test, input logic [19:0] addr,
                               input logic [31:0] data, input logic [31:0] exp);
        bus_write(addr, data);
        check_reg(test, addr, exp);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic reset_and_readback();
        logic [31:0] d;
        check_reg("reset out1_sw", peak_sim_pkg::ADDR_OUT1_SW, 32'd1);   // SRC_IN1
        check_reg("reset out2_sw", peak_sim_pkg::ADDR_OUT2_SW, 32'd0);
        check_reg("reset in1", peak_sim_pkg::ADDR_IN1, 32'd0);
        check_reg("reset in2", peak_sim_pkg::ADDR_IN2, 32'd0);
        check_reg("reset out1", peak_sim_pkg::ADDR_OUT1, 32'd0);
        check_reg("reset out2", peak_sim_pkg::ADDR_OUT2, 32'd0);
        check_reg("reset in_sel", peak_sim_pkg::ADDR_IN_SEL, 32'd0);
        check_reg("reset peak_pos", peak_sim_pkg::ADDR_PEAK_POS, 32'd0);
        check_reg("reset width", peak_sim_pkg::ADDR_WIDTH, 32'd8191);
        check_reg("reset drift_en", peak_sim_pkg::ADDR_DRIFT_EN, 32'd0);
        check_reg("reset drift_time", peak_sim_pkg::ADDR_DRIFT_TIME, 32'd13);
        // random write, masked read-back
        d = $random(seed);
        write_check("rb out1_sw", peak_sim_pkg::ADDR_OUT1_SW, d, {29'd0, d[2:0]});
        d = $random(seed);
        write_check("rb out2_sw", peak_sim_pkg::ADDR_OUT2_SW, d, {29'd0, d[2:0]});
        d = $random(seed);
        write_check("rb in_sel", peak_sim_pkg::ADDR_IN_SEL, d, {30'd0, d[1:0]});
        d = $random(seed);
        write_check("rb peak_pos", peak_sim_pkg::ADDR_PEAK_POS, d, sext_word(d[13:0]));
        d = $random(seed);
        write_check("rb width", peak_sim_pkg::ADDR_WIDTH, d, sext_word(d[13:0]));
        d = $random(seed);
        write_check("rb drift_time", peak_sim_pkg::ADDR_DRIFT_TIME, d, {28'd0, d[3:0]});
        // enable is the or of every data bit
        write_check("rb drift_en msb", peak_sim_pkg::ADDR_DRIFT_EN, 32'h8000_0000, 32'd1);
        write_check("rb drift_en off", peak_sim_pkg::ADDR_DRIFT_EN, 32'd0, 32'd0);
        check_reg("unknown offset", 20'h00044, 32'd0);
    endtask

    task automatic route_inputs();
        int a;
        int b;
        peak_sim_pkg::sample_t exp;
        for (int i = 0; i < 6; i++) begin
            case (i)
                0: begin a = 8191;  b = 8191;  end    // sum clips high
                1: begin a = -8192; b = 8191;  end    // diff clips low
                2: begin a = 8191;  b = -8192; end    // diff clips high
                3: begin a = -8192; b = -8192; end    // sum clips low
                default: begin
                    a = peak_sim_pkg::sample_t'($random(seed));
                    b = peak_sim_pkg::sample_t'($random(seed));
                end
            endcase
            @(negedge clk);
            in1 = peak_sim_pkg::sample_t'(a);
            in2 = peak_sim_pkg::sample_t'(b);
            // live inputs read back sign-extended
            check_reg("routing rb in1", peak_sim_pkg::ADDR_IN1,
                      sext_word(peak_sim_pkg::sample_t'(a)));
            check_reg("routing rb in2", peak_sim_pkg::ADDR_IN2,
                      sext_word(peak_sim_pkg::sample_t'(b)));
            for (int s = 1; s <= 4; s++) begin   // in1, in2, sum, diff
                bus_write(peak_sim_pkg::ADDR_OUT1_SW, s);
                bus_write(peak_sim_pkg::ADDR_OUT2_SW, s);
                repeat (3) @(negedge clk);
                exp = route_expect(s, a, b);
                compare_sample("routing out1", exp, dut_out[0]);
                compare_sample("routing out2", exp, dut_out[1]);
                check_reg("routing rb out1", peak_sim_pkg::ADDR_OUT1, sext_word(exp));
                check_reg("routing rb out2", peak_sim_pkg::ADDR_OUT2, sext_word(exp));
            end
        end
    endtask

    task automatic position_per_input();
        int a;
        int b;
        int w;
        int pp;
        int sel_v;
        bus_write(peak_sim_pkg::ADDR_DRIFT_EN, 32'd0);
        bus_write(peak_sim_pkg::ADDR_OUT1_SW, peak_sim_pkg::SRC_POS);
        for (int m = 0; m < 4; m++) begin
            w  = peak_sim_pkg::sample_t'($random(seed));
            pp = peak_sim_pkg::sample_t'($random(seed));
            a  = peak_sim_pkg::sample_t'($random(seed));
            b  = peak_sim_pkg::sample_t'($random(seed));
            bus_write(peak_sim_pkg::ADDR_IN_SEL, m);
            bus_write(peak_sim_pkg::ADDR_WIDTH, w);
            bus_write(peak_sim_pkg::ADDR_PEAK_POS, pp);
            in1 = peak_sim_pkg::sample_t'(a);
            in2 = peak_sim_pkg::sample_t'(b);
            repeat (4) @(negedge clk);
            case (m)
                0: sel_v = a;
                1: sel_v = b;
                2: sel_v = clip(a + b);
                default: sel_v = clip(a - b);
            endcase
            compare_sample("position", clip(pp + ((sel_v * w) >>> 13)), dut_out[0]);
        end
    endtask

    task automatic ramp_steps();
        peak_sim_pkg::sample_t first;
        int k;
        bus_write(peak_sim_pkg::ADDR_OUT1_SW, peak_sim_pkg::SRC_RAMP);
        repeat (2) @(negedge clk);
        for (int n = 0; n < 3; n++) begin
            k     = 1 + ($unsigned($random(seed)) % 50);
            first = dut_out[0];
            repeat (k) @(negedge clk);
            compare_sample("ramp", peak_sim_pkg::sample_t'(first + k), dut_out[0]);
        end
    endtask

    task automatic drift_triangle();
        int prev;
        int cur;
        bus_write(peak_sim_pkg::ADDR_OUT1_SW, peak_sim_pkg::SRC_DRIFT);
        bus_write(peak_sim_pkg::ADDR_DRIFT_TIME, 32'd0);   // fastest step
        bus_write(peak_sim_pkg::ADDR_DRIFT_EN, 32'd1);
        repeat (2) @(negedge clk);
        prev = dut_out[0];
        for (int n = 0; n < 200; n++) begin
            @(negedge clk);
            cur = dut_out[0];
            if (cur < -4095 || cur > 4096) begin
                $display("error drift range: expected -4095..4096, actual %0d", cur);
                stop_on_error();
            end
            if (cur - prev > 1 || prev - cur > 1) begin
                $display("error drift step: expected %0d +/- 1, actual %0d", prev, cur);
                stop_on_error();
            end
            prev = cur;
        end
        bus_write(peak_sim_pkg::ADDR_DRIFT_EN, 32'd0);
        repeat (3) @(negedge clk);
        compare_sample("drift off", 14'sd0, dut_out[0]);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        seed    = 32'hbe4f4c76;
        rst     = 1'b1;
        in1     = '0;
        in2     = '0;
        bus_req = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_and_readback();
        route_inputs();
        position_per_input();
        ramp_steps();
        drift_triangle();

        @(negedge clk);
        if (uut.u_assertions.fail_cnt != 0) begin
            $display("%0d assertion failures", uut.u_assertions.fail_cnt);
            stop_on_error();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- peak_sim.f
src/peak_sim_pkg.sv
src/peak_sim_regs.sv
src/peak_sim_drift.sv
src/peak_sim_sources.sv
src/peak_sim_out_route.sv
src/peak_sim_top.sv
dv/peak_sim_assertions.sv
dv/peak_sim_tb.sv

//--- src/peak_sim_drift.sv
`timescale 1ns/1ns

module peak_sim_drift (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_enable,
    input  logic [3:0]            i_time,     // log2 of the prescale
    output peak_sim_pkg::sample_t o_drift
);

    localparam int DRIFT_MID = 4095;   // centres counter/2 around zero

    logic [15:0] pre_cnt;
    logic [15:0] pre_max;
    logic [13:0] cnt;
    logic        dir_up;               // 1 counts up
    logic        at_max;
    logic        at_min;
    logic        step;
    peak_sim_pkg::sample_t half;

    // ----------------------------------------
    // prescaler
    // ----------------------------------------
    assign pre_max = 16'd1 << i_time;    // wraps after 2^time + 1 cycles

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_cnt <= '0;
        end else if (pre_cnt == pre_max) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 16'd1;
        end
    end

    assign step = (pre_cnt == 16'd0) && i_enable;   // one step per wrap

    // ----------------------------------------
    // up/down counter
    // ----------------------------------------
    assign at_max = &cnt;
    assign at_min = (cnt == 14'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            dir_up <= 1'b1;
        end else begin
            // turn around at either end, settles before the next step
            if (at_max) begin
                dir_up <= 1'b0;
            end else if (at_min) begin
                dir_up <= 1'b1;
            end
            if (!i_enable) begin
                cnt <= '0;                            // reload while off
            end else if (step) begin
                cnt <= dir_up ? cnt + 14'd1 : cnt - 14'd1;
            end
        end
    end

    // triangle of -4095 .. 4096
    assign half    = peak_sim_pkg::sample_t'({1'b0, cnt[13:1]});
    assign o_drift = i_enable ? half - peak_sim_pkg::sample_t'(DRIFT_MID) : '0;

endmodule

//--- src/peak_sim_out_route.sv
`timescale 1ns/1ns

module peak_sim_out_route #(
    parameter int N_OUT = 2
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  peak_sim_pkg::src_bus_t               i_src,
    input  peak_sim_pkg::src_sel_e [N_OUT-1:0]   i_sel,
    output peak_sim_pkg::sample_t  [N_OUT-1:0]   o_out
);

    // flat view of the source bus, index = src_sel_e
    peak_sim_pkg::sample_t [peak_sim_pkg::N_SRC-1:0] src_arr;

    assign src_arr = i_src;

    // ----------------------------------------
    // one registered select per fast output
    // ----------------------------------------
    for (genvar i = 0; i < N_OUT; i++) begin : g_chan
        peak_sim_pkg::sample_t out_q;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                out_q <= '0;                    // dacs idle at mid scale
            end else begin
                out_q <= src_arr[i_sel[i]];
            end
        end

        assign o_out[i] = out_q;   // one cycle after the source
    end

endmodule

//--- src/peak_sim_pkg.sv
package peak_sim_pkg;

    // ----------------------------------------
    // sample format
    // ----------------------------------------
    localparam int SAMPLE_W = 14;
    typedef logic signed [SAMPLE_W-1:0] sample_t;   // one adc / dac word

    localparam int SAT_MAX = 8191;    // positive full scale
    localparam int SAT_MIN = -8192;   // negative full scale

    localparam int N_SRC = 8;         // entries on the source bus

    // ----------------------------------------
    // selectors
    // ----------------------------------------
    typedef enum logic [1:0] {
        IN_1,
        IN_2,
        IN_SUM,
        IN_DIFF
    } in_sel_e;

    typedef enum logic [2:0] {
        SRC_ZERO,
        SRC_IN1,
        SRC_IN2,
        SRC_SUM,
        SRC_DIFF,
        SRC_RAMP,
        SRC_DRIFT,
        SRC_POS
    } src_sel_e;

    // register offsets, matched on addr[19:0]
    typedef enum logic [19:0] {
        ADDR_OUT1_SW    = 20'h00010,
        ADDR_OUT2_SW    = 20'h00014,
        ADDR_IN1        = 20'h00028,   // read only
        ADDR_IN2        = 20'h0002C,   // read only
        ADDR_OUT1       = 20'h00030,   // read only
        ADDR_OUT2       = 20'h00034,   // read only
        ADDR_IN_SEL     = 20'h00050,
        ADDR_PEAK_POS   = 20'h00064,
        ADDR_WIDTH      = 20'h0006C,
        ADDR_DRIFT_EN   = 20'h0007C,
        ADDR_DRIFT_TIME = 20'h00080
    } reg_addr_e;

    // ----------------------------------------
    // bundles
    // ----------------------------------------
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        wen;     // one-cycle write strobe
        logic        ren;     // one-cycle read strobe
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;
        logic        err;
    } bus_rsp_t;

    typedef struct packed {
        in_sel_e        in_sel;
        sample_t        peak_pos;
        sample_t        width;
        logic           drift_en;
        logic [3:0]     drift_time;
        src_sel_e [1:0] out_sel;      // one per fast output
    } cfg_t;

    // members run from SRC_POS down to SRC_ZERO, so the
    // bus viewed as sample_t [N_SRC-1:0] is indexed by src_sel_e
    typedef struct packed {
        sample_t pos;
        sample_t drift;
        sample_t ramp;
        sample_t diff;
        sample_t sum;
        sample_t in2;
        sample_t in1;
        sample_t zero;
    } src_bus_t;

endpackage

//--- src/peak_sim_regs.sv
`timescale 1ns/1ns

module peak_sim_regs #(
    parameter int N_OUT = 2
) (
    input  logic                                clk,
    input  logic                                rst,
    input  peak_sim_pkg::bus_req_t              i_bus,
    input  peak_sim_pkg::sample_t               i_in1,
    input  peak_sim_pkg::sample_t               i_in2,
    input  peak_sim_pkg::sample_t [N_OUT-1:0]   i_out,
    output peak_sim_pkg::bus_rsp_t              o_bus,
    output peak_sim_pkg::cfg_t                  o_cfg
);

    peak_sim_pkg::cfg_t cfg_q;
    logic [19:0]        addr;        // only the low 20 bits decode
    logic [31:0]        rd_data;
    logic [31:0]        rdata_q;
    logic               ack_q;

    // sign extension for signed read-back
    function automatic logic [31:0] sext(input peak_sim_pkg::sample_t v);
        return {{(32-peak_sim_pkg::SAMPLE_W){v[peak_sim_pkg::SAMPLE_W-1]}}, v};
    endfunction

    assign addr = i_bus.addr[19:0];

    // ----------------------------------------
    // write side
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_q.out_sel[0] <= peak_sim_pkg::SRC_IN1;    // out1 passes in1
            cfg_q.out_sel[1] <= peak_sim_pkg::SRC_ZERO;
            cfg_q.in_sel     <= peak_sim_pkg::IN_1;
            cfg_q.peak_pos   <= '0;
            cfg_q.width      <= 14'sd8191;                 // unity gain
            cfg_q.drift_en   <= 1'b0;
            cfg_q.drift_time <= 4'd13;
        end else if (i_bus.wen) begin
            case (addr)
                peak_sim_pkg::ADDR_OUT1_SW:
                    cfg_q.out_sel[0] <= peak_sim_pkg::src_sel_e'(i_bus.wdata[2:0]);
                peak_sim_pkg::ADDR_OUT2_SW:
                    cfg_q.out_sel[1] <= peak_sim_pkg::src_sel_e'(i_bus.wdata[2:0]);
                peak_sim_pkg::ADDR_IN_SEL:
                    cfg_q.in_sel <= peak_sim_pkg::in_sel_e'(i_bus.wdata[1:0]);
                peak_sim_pkg::ADDR_PEAK_POS:   cfg_q.peak_pos   <= i_bus.wdata[13:0];
                peak_sim_pkg::ADDR_WIDTH:      cfg_q.width      <= i_bus.wdata[13:0];
                peak_sim_pkg::ADDR_DRIFT_EN:   cfg_q.drift_en   <= |i_bus.wdata;   // any bit set
                peak_sim_pkg::ADDR_DRIFT_TIME: cfg_q.drift_time <= i_bus.wdata[3:0];
                default: ;   // read-only and unmapped, nothing to store
            endcase
        end
    end

    // ----------------------------------------
    // read side
    // ----------------------------------------
    always_comb begin
        rd_data = '0;   // unmapped offsets read zero
        case (addr)
            peak_sim_pkg::ADDR_OUT1_SW:    rd_data = {29'd0, cfg_q.out_sel[0]};
            peak_sim_pkg::ADDR_OUT2_SW:    rd_data = {29'd0, cfg_q.out_sel[1]};
            peak_sim_pkg::ADDR_IN1:        rd_data = sext(i_in1);    // live adc
            peak_sim_pkg::ADDR_IN2:        rd_data = sext(i_in2);
            peak_sim_pkg::ADDR_OUT1:       rd_data = sext(i_out[0]); // live dac
            peak_sim_pkg::ADDR_OUT2:       rd_data = sext(i_out[1]);
            peak_sim_pkg::ADDR_IN_SEL:     rd_data = {30'd0, cfg_q.in_sel};
            peak_sim_pkg::ADDR_PEAK_POS:   rd_data = sext(cfg_q.peak_pos);
            peak_sim_pkg::ADDR_WIDTH:      rd_data = sext(cfg_q.width);
            peak_sim_pkg::ADDR_DRIFT_EN:   rd_data = {31'd0, cfg_q.drift_en};
            peak_sim_pkg::ADDR_DRIFT_TIME: rd_data = {28'd0, cfg_q.drift_time};
            default: ;
        endcase
    end

    // read data valid together with ack
    always_ff @(posedge clk) begin
        rdata_q <= rd_data;
    end

    // ack one cycle after any strobe, reads of unknown offsets too
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_bus.wen | i_bus.ren;
        end
    end

    assign o_bus.rdata = rdata_q;
    assign o_bus.ack   = ack_q;
    assign o_bus.err   = 1'b0;   // no error source
    assign o_cfg       = cfg_q;

endmodule

//--- src/peak_sim_sources.sv
`timescale 1ns/1ns

module peak_sim_sources (
    input  logic                   clk,
    input  logic                   rst,
    input  peak_sim_pkg::sample_t  i_in1,
    input  peak_sim_pkg::sample_t  i_in2,
    input  peak_sim_pkg::cfg_t     i_cfg,
    input  peak_sim_pkg::sample_t  i_drift,
    output peak_sim_pkg::src_bus_t o_src
);

    // headroom for peak_pos + scaled + drift
    localparam int ACC_W = peak_sim_pkg::SAMPLE_W + 3;

    peak_sim_pkg::sample_t    sum_s;
    peak_sim_pkg::sample_t    diff_s;
    peak_sim_pkg::sample_t    sel_in;
    peak_sim_pkg::sample_t    sel_q;
    peak_sim_pkg::sample_t    ramp_q;
    peak_sim_pkg::sample_t    pos_s;
    logic signed [27:0]       prod;       // 14 x 14 product
    logic signed [ACC_W-1:0]  scaled;
    logic signed [ACC_W-1:0]  pos_sum;

    function automatic logic signed [ACC_W-1:0] ext(input peak_sim_pkg::sample_t v);
        return {{(ACC_W-peak_sim_pkg::SAMPLE_W){v[peak_sim_pkg::SAMPLE_W-1]}}, v};
    endfunction

    // clip to 14 bit full scale
    function automatic peak_sim_pkg::sample_t sat(input logic signed [ACC_W-1:0] v);
        if (v > peak_sim_pkg::SAT_MAX) begin
            return peak_sim_pkg::sample_t'(peak_sim_pkg::SAT_MAX);
        end
        if (v < peak_sim_pkg::SAT_MIN) begin
            return peak_sim_pkg::sample_t'(peak_sim_pkg::SAT_MIN);
        end
        return v[peak_sim_pkg::SAMPLE_W-1:0];
    endfunction

    // ----------------------------------------
    // input combinations
    // ----------------------------------------
    assign sum_s  = sat(ext(i_in1) + ext(i_in2));
    assign diff_s = sat(ext(i_in1) - ext(i_in2));

    always_comb begin
        case (i_cfg.in_sel)
            peak_sim_pkg::IN_2:    sel_in = i_in2;
            peak_sim_pkg::IN_SUM:  sel_in = sum_s;
            peak_sim_pkg::IN_DIFF: sel_in = diff_s;
            default:               sel_in = i_in1;
        endcase
    end

    // one pipeline stage ahead of the multiplier
    always_ff @(posedge clk) begin
        sel_q <= sel_in;
    end

    // ----------------------------------------
    // peak position
    // ----------------------------------------
    assign prod    = sel_q * i_cfg.width;
    assign scaled  = {{2{prod[27]}}, prod[27:13]};    // >>> 13, width 8191 ~ x1
    assign pos_sum = ext(i_cfg.peak_pos) + scaled + ext(i_drift);
    assign pos_s   = sat(pos_sum);

    // free-running scan ramp, wraps 8191 -> -8192
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ramp_q <= '0;
        end else begin
            ramp_q <= ramp_q + 14'sd1;
        end
    end

    assign o_src.zero  = '0;
    assign o_src.in1   = i_in1;
    assign o_src.in2   = i_in2;
    assign o_src.sum   = sum_s;
    assign o_src.diff  = diff_s;
    assign o_src.ramp  = ramp_q;
    assign o_src.drift = i_drift;
    assign o_src.pos   = pos_s;

endmodule

//--- src/peak_sim_top.sv
`timescale 1ns/1ns

module peak_sim_top #(
    parameter int N_OUT = 2   // fast outputs, matches cfg_t.out_sel
) (
    input  logic                                clk,
    input  logic                                rst,
    input  peak_sim_pkg::sample_t               i_in1,
    input  peak_sim_pkg::sample_t               i_in2,
    input  peak_sim_pkg::bus_req_t              i_bus,
    output peak_sim_pkg::sample_t [N_OUT-1:0]   o_out,
    output peak_sim_pkg::bus_rsp_t              o_bus
);

    peak_sim_pkg::cfg_t     cfg;     // register bank fields
    peak_sim_pkg::sample_t  drift;
    peak_sim_pkg::src_bus_t src;     // everything routable

    // ----------------------------------------
    // control
    // ----------------------------------------
    peak_sim_regs #(.N_OUT(N_OUT)) u_regs (
        .clk   (clk),
        .rst   (rst),
        .i_bus (i_bus),
        .i_in1 (i_in1),
        .i_in2 (i_in2),
        .i_out (o_out),     // dac values read back
        .o_bus (o_bus),
        .o_cfg (cfg)
    );

    // ----------------------------------------
    // signal path
    // ----------------------------------------
    peak_sim_drift u_drift (
        .clk      (clk),
        .rst      (rst),
        .i_enable (cfg.drift_en),
        .i_time   (cfg.drift_time),
        .o_drift  (drift)
    );

    peak_sim_sources u_sources (
        .clk     (clk),
        .rst     (rst),
        .i_in1   (i_in1),
        .i_in2   (i_in2),
        .i_cfg   (cfg),
        .i_drift (drift),
        .o_src   (src)
    );

    peak_sim_out_route #(.N_OUT(N_OUT)) u_out_route (
        .clk   (clk),
        .rst   (rst),
        .i_src (src),
        .i_sel (cfg.out_sel),
        .o_out (o_out)
    );

endmodule
